// File: source/axil_soc_pkg.sv
package axil_soc_pkg;

	// Bus widths
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

	typedef enum logic [1:0] {
		REGION_MAIN,
		REGION_BOOT,
		REGION_NONE
	} region_t;

	// Memory map, window size given as low address bits
	localparam addr_t MAIN_BASE      = 32'h0000_0000;
	localparam int    MAIN_ADDR_BITS = 25;
	localparam addr_t BOOT_BASE      = 32'h0201_0000;
	localparam int    BOOT_ADDR_BITS = 15;

	localparam int MAIN_DEPTH_WORDS = 1024;	// 32-bit words
	localparam int BOOT_DEPTH_WORDS = 256;

	// Power-on hold of the fabric reset
	localparam int RESET_HOLD_CYCLES = 255;
	localparam int RESET_CNT_BITS    = $clog2(RESET_HOLD_CYCLES + 1);

	typedef logic [RESET_CNT_BITS-1:0] rst_cnt_t;

endpackage

// File: source/axil_if.sv
`timescale 1ns/1ps

interface axil_if import axil_soc_pkg::*; ();

	addr_t awaddr;
	logic  awvalid;
	logic  awready;

	data_t wdata;
	strb_t wstrb;
	logic  wvalid;
	logic  wready;

	resp_t bresp;
	logic  bvalid;
	logic  bready;

	addr_t araddr;
	logic  arvalid;
	logic  arready;

	data_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;

	modport master (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

endinterface

// File: source/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer import axil_soc_pkg::*; (
	input  logic hdmi_pixClk,
	input  logic arst_n,
	output logic bus_rst_n,
	output logic bus_ready
);

	rst_cnt_t count;
	logic     done;

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			done  <= 1'b0;
		end else begin
			if (count != rst_cnt_t'(RESET_HOLD_CYCLES))
				count <= count + 1'b1;	// Saturates at the hold length
			done <= (count == rst_cnt_t'(RESET_HOLD_CYCLES));
		end
	end

	// Release is synchronous to the pixel clock
	assign bus_rst_n = done;
	assign bus_ready = done;

endmodule

// File: source/axil_decoder.sv
`timescale 1ns/1ps

module axil_decoder import axil_soc_pkg::*; (
	input  logic   hdmi_pixClk,
	input  logic   bus_rst_n,
	input  addr_t  awaddr,
	input  logic   awvalid,
	output logic   awready,
	input  data_t  wdata,
	input  strb_t  wstrb,
	input  logic   wvalid,
	output logic   wready,
	output resp_t  bresp,
	output logic   bvalid,
	input  logic   bready,
	input  addr_t  araddr,
	input  logic   arvalid,
	output logic   arready,
	output data_t  rdata,
	output resp_t  rresp,
	output logic   rvalid,
	input  logic   rready,
	axil_if.master main_bus,
	axil_if.master boot_bus
);

	typedef enum logic [1:0] {IDLE, FORWARD, RESPOND} state_t;

	state_t  wr_state, rd_state;
	region_t wr_region, rd_region;
	region_t aw_region, ar_region;
	logic    aw_rdy, ar_rdy;
	logic    w_accept, r_accept;
	logic    w_fwd, r_fwd;	// Request not yet taken by the slave
	logic    sel_wr_ack, sel_rd_ack;
	logic    sel_bvalid, sel_rvalid;
	resp_t   sel_bresp, sel_rresp;
	data_t   sel_rdata;
	addr_t   aw_addr_q, ar_addr_q;
	data_t   w_data_q;
	strb_t   w_strb_q;

	function automatic region_t classify(input addr_t addr);
		if (addr[ADDR_WIDTH-1:MAIN_ADDR_BITS] == MAIN_BASE[ADDR_WIDTH-1:MAIN_ADDR_BITS])
			return REGION_MAIN;
		if (addr[ADDR_WIDTH-1:BOOT_ADDR_BITS] == BOOT_BASE[ADDR_WIDTH-1:BOOT_ADDR_BITS])
			return REGION_BOOT;
		return REGION_NONE;
	endfunction

	assign aw_region = classify(awaddr);
	assign ar_region = classify(araddr);
	assign w_accept  = aw_rdy && awvalid && wvalid;
	assign r_accept  = ar_rdy && arvalid;

	// Write channel
	always_ff @(posedge hdmi_pixClk or negedge bus_rst_n) begin
		if (!bus_rst_n) begin
			wr_state  <= IDLE;
			wr_region <= REGION_NONE;
			aw_rdy    <= 1'b0;
			w_fwd     <= 1'b0;
		end else begin
			aw_rdy <= 1'b0;
			case (wr_state)
				IDLE: begin
					if (w_accept) begin
						wr_region <= aw_region;
						if (aw_region == REGION_NONE) begin
							wr_state <= RESPOND;
						end else begin
							wr_state <= FORWARD;
							w_fwd    <= 1'b1;
						end
					end else if (awvalid && wvalid && !aw_rdy) begin
						aw_rdy <= 1'b1;
					end
				end
				FORWARD: begin
					if (sel_wr_ack)
						w_fwd <= 1'b0;
					if (sel_bvalid && bready)
						wr_state <= IDLE;
				end
				RESPOND: if (bready) wr_state <= IDLE;
				default: wr_state <= IDLE;
			endcase
		end
	end

	// Read channel
	always_ff @(posedge hdmi_pixClk or negedge bus_rst_n) begin
		if (!bus_rst_n) begin
			rd_state  <= IDLE;
			rd_region <= REGION_NONE;
			ar_rdy    <= 1'b0;
			r_fwd     <= 1'b0;
		end else begin
			ar_rdy <= 1'b0;
			case (rd_state)
				IDLE: begin
					if (r_accept) begin
						rd_region <= ar_region;
						if (ar_region == REGION_NONE) begin
							rd_state <= RESPOND;
						end else begin
							rd_state <= FORWARD;
							r_fwd    <= 1'b1;
						end
					end else if (arvalid && !ar_rdy) begin
						ar_rdy <= 1'b1;
					end
				end
				FORWARD: begin
					if (sel_rd_ack)
						r_fwd <= 1'b0;
					if (sel_rvalid && rready)
						rd_state <= IDLE;
				end
				RESPOND: if (rready) rd_state <= IDLE;
				default: rd_state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (w_accept) begin
			aw_addr_q <= awaddr;
			w_data_q  <= wdata;
			w_strb_q  <= wstrb;
		end
		if (r_accept)
			ar_addr_q <= araddr;
	end

	// Selected slave
	assign sel_wr_ack = (wr_region == REGION_MAIN) ? (main_bus.awready && main_bus.wready)
	                                               : (boot_bus.awready && boot_bus.wready);
	assign sel_rd_ack = (rd_region == REGION_MAIN) ? main_bus.arready : boot_bus.arready;
	assign sel_bvalid = (wr_region == REGION_MAIN) ? main_bus.bvalid : boot_bus.bvalid;
	assign sel_bresp  = (wr_region == REGION_MAIN) ? main_bus.bresp : boot_bus.bresp;
	assign sel_rvalid = (rd_region == REGION_MAIN) ? main_bus.rvalid : boot_bus.rvalid;
	assign sel_rresp  = (rd_region == REGION_MAIN) ? main_bus.rresp : boot_bus.rresp;
	assign sel_rdata  = (rd_region == REGION_MAIN) ? main_bus.rdata : boot_bus.rdata;

	assign main_bus.awaddr  = aw_addr_q;
	assign main_bus.wdata   = w_data_q;
	assign main_bus.wstrb   = w_strb_q;
	assign main_bus.awvalid = w_fwd && (wr_region == REGION_MAIN);
	assign main_bus.wvalid  = w_fwd && (wr_region == REGION_MAIN);
	assign main_bus.bready  = bready && (wr_state == FORWARD) && (wr_region == REGION_MAIN);
	assign main_bus.araddr  = ar_addr_q;
	assign main_bus.arvalid = r_fwd && (rd_region == REGION_MAIN);
	assign main_bus.rready  = rready && (rd_state == FORWARD) && (rd_region == REGION_MAIN);

	assign boot_bus.awaddr  = aw_addr_q;
	assign boot_bus.wdata   = w_data_q;
	assign boot_bus.wstrb   = w_strb_q;
	assign boot_bus.awvalid = w_fwd && (wr_region == REGION_BOOT);
	assign boot_bus.wvalid  = w_fwd && (wr_region == REGION_BOOT);
	assign boot_bus.bready  = bready && (wr_state == FORWARD) && (wr_region == REGION_BOOT);
	assign boot_bus.araddr  = ar_addr_q;
	assign boot_bus.arvalid = r_fwd && (rd_region == REGION_BOOT);
	assign boot_bus.rready  = rready && (rd_state == FORWARD) && (rd_region == REGION_BOOT);

	// Manager side, unmapped accesses answer from RESPOND
	assign awready = aw_rdy;
	assign wready  = aw_rdy;
	assign bvalid  = (wr_state == FORWARD) ? sel_bvalid : (wr_state == RESPOND);
	assign bresp   = (wr_state == FORWARD) ? sel_bresp : RESP_DECERR;
	assign arready = ar_rdy;
	assign rvalid  = (rd_state == FORWARD) ? sel_rvalid : (rd_state == RESPOND);
	assign rresp   = (rd_state == FORWARD) ? sel_rresp : RESP_DECERR;
	assign rdata   = (rd_state == FORWARD) ? sel_rdata : '0;

endmodule

// File: source/axil_ram.sv
`timescale 1ns/1ps

module axil_ram import axil_soc_pkg::*; #(
	parameter int DEPTH_WORDS = BOOT_DEPTH_WORDS
) (
	input  logic  hdmi_pixClk,
	input  logic  bus_rst_n,
	axil_if.slave bus
);

	data_t mem [DEPTH_WORDS];

	logic  aw_rdy, ar_rdy;
	logic  b_vld, r_vld;
	logic  wr_fire, rd_fire;
	logic  [$clog2(DEPTH_WORDS)-1:0] wr_idx, rd_idx;
	data_t rd_data;

	// Word index wraps at the memory depth
	assign wr_idx  = bus.awaddr[2 +: $clog2(DEPTH_WORDS)];
	assign rd_idx  = bus.araddr[2 +: $clog2(DEPTH_WORDS)];
	assign wr_fire = aw_rdy && bus.awvalid && bus.wvalid;
	assign rd_fire = ar_rdy && bus.arvalid;

	always_ff @(posedge hdmi_pixClk or negedge bus_rst_n) begin
		if (!bus_rst_n) begin
			aw_rdy <= 1'b0;
			ar_rdy <= 1'b0;
			b_vld  <= 1'b0;
			r_vld  <= 1'b0;
		end else begin
			// One-cycle ready pulse, held off while a response is pending
			aw_rdy <= bus.awvalid && bus.wvalid && !aw_rdy && !b_vld;
			ar_rdy <= bus.arvalid && !ar_rdy && !r_vld;

			if (wr_fire)
				b_vld <= 1'b1;
			else if (bus.bready)
				b_vld <= 1'b0;

			if (rd_fire)
				r_vld <= 1'b1;
			else if (bus.rready)
				r_vld <= 1'b0;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_fire) begin
			for (int b = 0; b < STRB_WIDTH; b++) begin
				if (bus.wstrb[b])
					mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (rd_fire)
			rd_data <= mem[rd_idx];	// Held until the next read
	end

	assign bus.awready = aw_rdy;
	assign bus.wready  = aw_rdy;
	assign bus.bvalid  = b_vld;
	assign bus.bresp   = RESP_OKAY;
	assign bus.arready = ar_rdy;
	assign bus.rvalid  = r_vld;
	assign bus.rdata   = rd_data;
	assign bus.rresp   = RESP_OKAY;

endmodule

// File: source/axil_soc_top.sv
`timescale 1ns/1ps

module axil_soc_top import axil_soc_pkg::*; (
	input  logic  hdmi_pixClk,
	input  logic  arst_n,
	input  addr_t awaddr,
	input  logic  awvalid,
	output logic  awready,
	input  data_t wdata,
	input  strb_t wstrb,
	input  logic  wvalid,
	output logic  wready,
	output resp_t bresp,
	output logic  bvalid,
	input  logic  bready,
	input  addr_t araddr,
	input  logic  arvalid,
	output logic  arready,
	output data_t rdata,
	output resp_t rresp,
	output logic  rvalid,
	input  logic  rready,
	output logic  bus_ready
);

	logic bus_rst_n;

	axil_if main_bus ();
	axil_if boot_bus ();

	reset_sequencer u_reset (
		.hdmi_pixClk (hdmi_pixClk),
		.arst_n      (arst_n),
		.bus_rst_n   (bus_rst_n),
		.bus_ready   (bus_ready)
	);

	// Single manager port, stands in for the CPU
	axil_decoder u_decoder (
		.hdmi_pixClk (hdmi_pixClk),
		.bus_rst_n   (bus_rst_n),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.main_bus    (main_bus),
		.boot_bus    (boot_bus)
	);

	axil_ram #(.DEPTH_WORDS(MAIN_DEPTH_WORDS)) u_main_ram (
		.hdmi_pixClk (hdmi_pixClk),
		.bus_rst_n   (bus_rst_n),
		.bus         (main_bus)
	);

	axil_ram #(.DEPTH_WORDS(BOOT_DEPTH_WORDS)) u_boot_ram (
		.hdmi_pixClk (hdmi_pixClk),
		.bus_rst_n   (bus_rst_n),
		.bus         (boot_bus)
	);

endmodule

// File: test/axil_soc_sva.sv
`timescale 1ns/1ps

module axil_soc_sva import axil_soc_pkg::*; (
	input logic  hdmi_pixClk,
	input logic  arst_n,
	input logic  bus_ready,
	input logic  awvalid,
	input logic  awready,
	input logic  wvalid,
	input logic  wready,
	input logic  arready,
	input resp_t bresp,
	input logic  bvalid,
	input logic  bready,
	input data_t rdata,
	input resp_t rresp,
	input logic  rvalid,
	input logic  rready
);

	// Fabric stays quiet until the reset count completes
	a_quiet_in_reset: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		!bus_ready |-> !(awready || wready || arready || bvalid || rvalid))
		else $error("handshake output high while bus_ready is low");

	a_b_hold: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response dropped or changed before bready");

	a_r_hold: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read response dropped or changed before rready");

	a_aw_w_pair: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		awready || wready |-> awready && wready && awvalid && wvalid)	// Write accepted as one beat
		else $error("awready or wready high alone or without both valids");

endmodule

bind axil_soc_top axil_soc_sva u_sva (
	.hdmi_pixClk (hdmi_pixClk),
	.arst_n      (arst_n),
	.bus_ready   (bus_ready),
	.awvalid     (awvalid),
	.awready     (awready),
	.wvalid      (wvalid),
	.wready      (wready),
	.arready     (arready),
	.bresp       (bresp),
	.bvalid      (bvalid),
	.bready      (bready),
	.rdata       (rdata),
	.rresp       (rresp),
	.rvalid      (rvalid),
	.rready      (rready)
);

// File: test/axil_soc_tb.sv
`timescale 1ns/1ps

module axil_soc_tb import axil_soc_pkg::*; ();

	localparam int SEED           = 28;
	localparam int NUM_TESTS      = 24;
	localparam int TIMEOUT_CYCLES = RESET_HOLD_CYCLES + 50 + 20 * NUM_TESTS;

	typedef enum logic {OP_WRITE, OP_READ} op_e;

	typedef struct {
		string name;
		op_e   op;
		addr_t addr;
		data_t data;
		strb_t strb;
		data_t exp_data;
		resp_t exp_resp;
	} entry_t;

	logic  hdmi_pixClk;
	logic  arst_n;
	addr_t awaddr;
	logic  awvalid;
	logic  awready;
	data_t wdata;
	strb_t wstrb;
	logic  wvalid;
	logic  wready;
	resp_t bresp;
	logic  bvalid;
	logic  bready;
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	data_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;
	logic  bus_ready;

	entry_t tests [NUM_TESTS];
	int     n_entries;
	int     errors;
	int     passed;
	int     failed;
	int     cycle_count;

	axil_soc_top u_dut (.*);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #5 hdmi_pixClk = ~hdmi_pixClk;
	end

	function automatic void add_entry(input string name, input op_e op, input addr_t addr,
			input data_t data, input strb_t strb, input data_t exp_data, input resp_t exp_resp);
		tests[n_entries].name     = name;
		tests[n_entries].op       = op;
		tests[n_entries].addr     = addr;
		tests[n_entries].data     = data;
		tests[n_entries].strb     = strb;
		tests[n_entries].exp_data = exp_data;
		tests[n_entries].exp_resp = exp_resp;
		n_entries++;
	endfunction

	function automatic void load_table();
		add_entry("main_wr_000", OP_WRITE, 32'h0000_0000, 32'h1111_1111, 4'hF, '0, RESP_OKAY);
		add_entry("main_wr_010", OP_WRITE, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF, '0, RESP_OKAY);
		add_entry("main_wr_014", OP_WRITE, 32'h0000_0014, 32'h1234_5678, 4'hF, '0, RESP_OKAY);
		add_entry("main_rd_010", OP_READ, 32'h0000_0010, '0, '0, 32'hDEAD_BEEF, RESP_OKAY);
		add_entry("main_rd_014", OP_READ, 32'h0000_0014, '0, '0, 32'h1234_5678, RESP_OKAY);
		// Bytes 0 and 2 replaced
		add_entry("strb_wr_010", OP_WRITE, 32'h0000_0010, 32'hA5A5_A5A5, 4'b0101, '0, RESP_OKAY);
		add_entry("strb_rd_010", OP_READ, 32'h0000_0010, '0, '0, 32'hDEA5_BEA5, RESP_OKAY);
		add_entry("main_wr_100", OP_WRITE, 32'h0000_0100, 32'hCAFE_0001, 4'hF, '0, RESP_OKAY);
		add_entry("boot_wr_000", OP_WRITE, 32'h0201_0000, 32'h2222_2222, 4'hF, '0, RESP_OKAY);
		add_entry("boot_wr_100", OP_WRITE, 32'h0201_0100, 32'hB007_0001, 4'hF, '0, RESP_OKAY);
		add_entry("main_rd_100", OP_READ, 32'h0000_0100, '0, '0, 32'hCAFE_0001, RESP_OKAY);
		add_entry("boot_rd_100", OP_READ, 32'h0201_0100, '0, '0, 32'hB007_0001, RESP_OKAY);
		add_entry("boot_strb_wr", OP_WRITE, 32'h0201_0100, 32'h7700_0000, 4'b1000, '0, RESP_OKAY);
		add_entry("boot_strb_rd", OP_READ, 32'h0201_0100, '0, '0, 32'h7707_0001, RESP_OKAY);
		// Unmapped windows, the low bits alias RAM words written above
		add_entry("unmap_wr_0200_0000", OP_WRITE, 32'h0200_0000, '1, 4'hF, '0, RESP_DECERR);
		add_entry("unmap_wr_0200_0100", OP_WRITE, 32'h0200_0100, '1, 4'hF, '0, RESP_DECERR);
		add_entry("unmap_wr_8000_0000", OP_WRITE, 32'h8000_0000, '1, 4'hF, '0, RESP_DECERR);
		add_entry("unmap_rd_0200_0000", OP_READ, 32'h0200_0000, '0, '0, '0, RESP_DECERR);
		add_entry("unmap_rd_0200_0100", OP_READ, 32'h0200_0100, '0, '0, '0, RESP_DECERR);
		add_entry("unmap_rd_8000_0000", OP_READ, 32'h8000_0000, '0, '0, '0, RESP_DECERR);
		add_entry("main_rd_000_after", OP_READ, 32'h0000_0000, '0, '0, 32'h1111_1111, RESP_OKAY);
		add_entry("main_rd_100_after", OP_READ, 32'h0000_0100, '0, '0, 32'hCAFE_0001, RESP_OKAY);
		add_entry("boot_rd_000_after", OP_READ, 32'h0201_0000, '0, '0, 32'h2222_2222, RESP_OKAY);
		add_entry("boot_rd_100_after", OP_READ, 32'h0201_0100, '0, '0, 32'h7707_0001, RESP_OKAY);
	endfunction

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp, input resp_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected %s, actual %s (%b)", name, exp.name(), act.name(), act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d mismatches", name, errors - errs_before);
		end
	endtask

	// Counts negedges after release until bus_ready is seen
	task automatic watch_reset_release();
		int cycles;
		cycles = 0;
		@(negedge hdmi_pixClk);
		while (!bus_ready && cycles < RESET_HOLD_CYCLES + 2) begin
			check_flag("reset/awready", 1'b0, awready);
			check_flag("reset/wready", 1'b0, wready);
			check_flag("reset/arready", 1'b0, arready);
			check_flag("reset/bvalid", 1'b0, bvalid);
			check_flag("reset/rvalid", 1'b0, rvalid);
			@(negedge hdmi_pixClk);
			cycles++;
		end
		if (!bus_ready) begin
			$display("reset: bus_ready did not rise within %0d cycles", cycles);
			errors++;
		end else if (cycles < RESET_HOLD_CYCLES) begin
			$display("reset: bus_ready rose early, after %0d cycles", cycles);
			errors++;
		end
	endtask

	task automatic write_word(input addr_t addr, input data_t data, input strb_t strb,
			output resp_t resp);
		int delay;
		delay = $urandom % 6;
		@(posedge hdmi_pixClk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(negedge hdmi_pixClk);
		while (!(awready && wready)) @(negedge hdmi_pixClk);
		@(posedge hdmi_pixClk);	// Address and data transfer here
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		repeat (delay) @(posedge hdmi_pixClk);
		bready <= 1'b1;
		@(negedge hdmi_pixClk);
		while (!bvalid) @(negedge hdmi_pixClk);
		resp = bresp;
		@(posedge hdmi_pixClk);
		bready <= 1'b0;
	endtask

	task automatic read_word(input addr_t addr, output data_t data, output resp_t resp);
		int delay;
		delay = $urandom % 6;
		@(posedge hdmi_pixClk);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(negedge hdmi_pixClk);
		while (!arready) @(negedge hdmi_pixClk);
		@(posedge hdmi_pixClk);
		arvalid <= 1'b0;
		repeat (delay) @(posedge hdmi_pixClk);
		rready <= 1'b1;
		@(negedge hdmi_pixClk);
		while (!rvalid) @(negedge hdmi_pixClk);
		data = rdata;
		resp = rresp;
		@(posedge hdmi_pixClk);
		rready <= 1'b0;
	endtask

	initial begin
		int    errs_before;
		resp_t got_resp;
		data_t got_data;
		void'($urandom(SEED));
		arst_n    = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		n_entries = 0;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		load_table();

		repeat (2) @(posedge hdmi_pixClk);
		arst_n <= 1'b1;
		errs_before = errors;
		watch_reset_release();
		report_test("reset", errs_before);

		for (int i = 0; i < n_entries; i++) begin
			errs_before = errors;
			if (tests[i].op == OP_WRITE) begin
				write_word(tests[i].addr, tests[i].data, tests[i].strb, got_resp);
				check_resp(tests[i].name, tests[i].exp_resp, got_resp);
			end else begin
				read_word(tests[i].addr, got_data, got_resp);
				check_resp(tests[i].name, tests[i].exp_resp, got_resp);
				check_data(tests[i].name, tests[i].exp_data, got_data);
			end
			report_test(tests[i].name, errs_before);
		end

		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0 && errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Run limit from the reset hold and the table length
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge hdmi_pixClk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: project.f
source/axil_soc_pkg.sv
source/axil_if.sv
source/reset_sequencer.sv
source/axil_decoder.sv
source/axil_ram.sv
source/axil_soc_top.sv
test/axil_soc_sva.sv
test/axil_soc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= axil_soc_tb
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation reported failures"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
